// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_tb_sim > build.log 2>&1 \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { grep -q "All tests passed!" sim.log && echo "RESULT: PASS" && exit 0; } \
    || { echo "RESULT: FAIL"; exit 1; }

// File: sim.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/fwd_if.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu_top.sv
testbench/cpu_tb.sv

// File: testbench/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    typedef struct {
        logic                  valid;    // instr_valid for this slot
        cpu_isa_pkg::opcode_e  op;
        cpu_isa_pkg::reg_idx_t ra;
        cpu_isa_pkg::reg_idx_t rb;
        cpu_isa_pkg::data_t    in_val;   // in_port driven with the instruction
        cpu_isa_pkg::data_t    exp_out;  // only used on OUT rows
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    logic [7:0]         instr;
    cpu_isa_pkg::data_t in_port;
    logic               out_valid;
    cpu_isa_pkg::data_t out_port;

    row_t               rows[$];          // program table
    int                 drive_cycle[$];   // cycle count seen when each row was driven
    cpu_isa_pkg::data_t exp_q[$];         // expected OUT values, in order
    int                 idx_q[$];         // row index of each expected OUT
    int                 cycle = 0;
    int                 cycle_limit = 0;
    int                 out_count = 0;
    int                 n_outs = 0;
    bit                 table_ready = 1'b0;

    cpu_top i_dut (
        .clk (clk), .rst_n (rst_n),
        .instr_valid (instr_valid), .instr (instr), .in_port (in_port),
        .out_valid (out_valid), .out_port (out_port)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_run(input string why);
        $display("Test failures found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input cpu_isa_pkg::data_t got,
                              input cpu_isa_pkg::data_t exp_val);
        if (got !== exp_val) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp_val);
            stop_run("data value mismatch");
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp_val);
        if (got != exp_val) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp_val);
            stop_run("strobe arrived on the wrong cycle");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp_val);
        if (got != exp_val) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp_val);
            stop_run("wrong number of outputs");
        end
    endtask

    task automatic add_row(input int v, input cpu_isa_pkg::opcode_e op, input int ra,
                           input int rb, input cpu_isa_pkg::data_t in_val,
                           input cpu_isa_pkg::data_t exp_out);
        row_t r;
        r.valid   = (v != 0);
        r.op      = op;
        r.ra      = cpu_isa_pkg::reg_idx_t'(ra);
        r.rb      = cpu_isa_pkg::reg_idx_t'(rb);
        r.in_val  = in_val;
        r.exp_out = exp_out;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'h00);  // all regs zero after reset
        add_row(1, cpu_isa_pkg::op_out, 1, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_out, 2, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_out, 3, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_in,  0, 0, 8'h5a, 8'h00);
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'h5a);  // distance 1
        add_row(1, cpu_isa_pkg::op_in,  1, 0, 8'hc3, 8'h00);
        add_row(0, cpu_isa_pkg::op_in,  1, 0, 8'hff, 8'h00);  // idle, must not load r1
        add_row(1, cpu_isa_pkg::op_out, 1, 0, 8'h00, 8'hc3);  // distance 2
        add_row(1, cpu_isa_pkg::op_mov, 2, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_in,  3, 0, 8'hf0, 8'h00);
        add_row(0, cpu_isa_pkg::op_inc, 2, 0, 8'h00, 8'h00);  // idle inc ignored
        add_row(1, cpu_isa_pkg::op_out, 2, 0, 8'h00, 8'h5a);  // distance 3, write-through
        add_row(1, cpu_isa_pkg::op_add, 2, 1, 8'h00, 8'h00);  // 5a + c3 wraps
        add_row(1, cpu_isa_pkg::op_out, 2, 0, 8'h00, 8'h1d);
        add_row(1, cpu_isa_pkg::op_add, 3, 3, 8'h00, 8'h00);  // f0 + f0 overflow
        add_row(1, cpu_isa_pkg::op_out, 3, 0, 8'h00, 8'he0);
        add_row(1, cpu_isa_pkg::op_in,  0, 0, 8'h10, 8'h00);
        add_row(1, cpu_isa_pkg::op_in,  1, 0, 8'h20, 8'h00);
        add_row(1, cpu_isa_pkg::op_sub, 0, 1, 8'h00, 8'h00);  // 10 - 20 underflow
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'hf0);
        add_row(1, cpu_isa_pkg::op_and, 0, 3, 8'h00, 8'h00);  // f0 & e0
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'he0);
        add_row(1, cpu_isa_pkg::op_in,  1, 0, 8'h0f, 8'h00);
        add_row(1, cpu_isa_pkg::op_or,  1, 2, 8'h00, 8'h00);  // 0f | 1d
        add_row(1, cpu_isa_pkg::op_out, 1, 0, 8'h00, 8'h1f);
        add_row(1, cpu_isa_pkg::op_not, 2, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_out, 2, 0, 8'h00, 8'he2);
        add_row(1, cpu_isa_pkg::op_inc, 3, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_inc, 3, 0, 8'h00, 8'h00);  // chained on itself
        add_row(1, cpu_isa_pkg::op_out, 3, 0, 8'h00, 8'he2);
        add_row(1, cpu_isa_pkg::op_in,  0, 0, 8'hff, 8'h00);
        add_row(1, cpu_isa_pkg::op_inc, 0, 0, 8'h00, 8'h00);  // ff + 1 wraps
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_dec, 0, 0, 8'h00, 8'h00);  // 00 - 1 wraps
        add_row(1, cpu_isa_pkg::op_out, 0, 0, 8'h00, 8'hff);
        add_row(1, cpu_isa_pkg::op_in,  1, 0, 8'h01, 8'h00);
        add_row(1, cpu_isa_pkg::op_dec, 1, 0, 8'h00, 8'h00);
        add_row(0, cpu_isa_pkg::op_dec, 1, 0, 8'h00, 8'h00);
        add_row(0, cpu_isa_pkg::op_out, 1, 0, 8'h00, 8'h00);  // idle out, no strobe
        add_row(1, cpu_isa_pkg::op_out, 1, 0, 8'h00, 8'h00);  // distance 3 across idles
        add_row(1, cpu_isa_pkg::op_mov, 3, 0, 8'h00, 8'h00);
        add_row(1, cpu_isa_pkg::op_out, 3, 0, 8'h00, 8'hff);
    endtask

    initial begin : driver
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 8'h00;
        in_port     = 8'h00;
        build_table();
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].valid && rows[i].op == cpu_isa_pkg::op_out) n_outs++;
        end
        cycle_limit = rows.size() + 5 + 4 + 20;  // table + reset + pipe + spare
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            drive_cycle.push_back(cycle);  // old count, accepted one edge later
            instr_valid <= rows[i].valid;
            instr       <= {rows[i].op, rows[i].ra, rows[i].rb};
            in_port     <= rows[i].in_val;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= 8'h00;
        in_port     <= 8'h00;
        wait (out_count == n_outs);
        repeat (4) @(posedge clk);  // room for a stray strobe
        check_count("out_valid count", out_count, n_outs);
        $display("All tests passed!");
        $finish;
    end

    initial begin : out_checker
        int                 idx;
        cpu_isa_pkg::data_t exp_val;
        wait (table_ready);
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].valid && rows[i].op == cpu_isa_pkg::op_out) begin
                exp_q.push_back(rows[i].exp_out);
                idx_q.push_back(i);
            end
        end
        forever begin
            @(negedge clk);  // outputs settled mid-cycle
            if (out_valid === 1'b1) begin
                out_count++;  // every strobe, surplus ones included
                if (exp_q.size() != 0) begin
                    idx     = idx_q.pop_front();
                    exp_val = exp_q.pop_front();
                    check_cycle("out_valid cycle", cycle, drive_cycle[idx] + 6);  // edge N+4
                    check_data("out_port", out_port, exp_val);
                end
            end
        end
    end

    initial begin : watchdog
        wait (table_ready);
        wait (cycle >= cycle_limit);
        stop_run("run timed out before all outputs arrived");
    end

endmodule

`default_nettype wire

// File: verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int data_w    = 8;  // datapath width
    localparam int reg_count = 4;  // general registers r0..r3

    typedef logic [data_w-1:0] data_t;                // one data word
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;  // register index

    // instr[7:4] holds the opcode
    // instr[3:2] holds ra, which is also the destination
    // instr[1:0] holds rb
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,   // ra <- rb
        op_add = 4'd2,   // ra <- ra + rb
        op_sub = 4'd3,   // ra <- ra - rb
        op_and = 4'd4,
        op_or  = 4'd5,
        op_not = 4'd6,   // ra <- ~ra
        op_inc = 4'd7,
        op_dec = 4'd8,
        op_in  = 4'd9,   // ra <- in_port
        op_out = 4'd10   // out_port <- ra
    } opcode_e;  // codes 11..15 unused, they run as nop

endpackage

`default_nettype wire

// File: verilog/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    typedef enum logic [3:0] {
        alu_pass_b  = 4'd0,  // mov, and out (b is ra then)
        alu_add     = 4'd1,
        alu_sub     = 4'd2,
        alu_and     = 4'd3,
        alu_or      = 4'd4,
        alu_not_a   = 4'd5,
        alu_inc_a   = 4'd6,
        alu_dec_a   = 4'd7,
        alu_pass_in = 4'd8   // sampled input port
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none = 2'd0,  // value read in decode
        fwd_mem  = 2'd1,  // EX/MEM result, one ahead
        fwd_wb   = 2'd2   // MEM/WB result, two ahead
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    reg_write;  // write result to ra
        logic    io_write;   // present result on out_port
    } ctrl_t;

    // bubble contents, loaded on reset and for idle slots
    localparam ctrl_t ctrl_nop = '{
        alu_op:    alu_pass_b,
        reg_write: 1'b0,
        io_write:  1'b0
    };

endpackage

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                instr_valid,
    input  wire [7:0]          instr,
    input  cpu_isa_pkg::data_t in_port,
    output logic               out_valid,
    output cpu_isa_pkg::data_t out_port
);

    cpu_isa_pkg::reg_idx_t ra_addr, rb_addr;      // decode reads
    cpu_isa_pkg::data_t    ra_val, rb_val;
    cpu_pipe_pkg::ctrl_t   ex_ctrl, mem_ctrl;
    cpu_isa_pkg::reg_idx_t ex_ra, ex_rb, mem_rd;
    cpu_isa_pkg::data_t    ex_ra_val, ex_rb_val, ex_in_val;
    cpu_isa_pkg::data_t    mem_result;
    logic                  rf_we;                 // writeback to rf
    cpu_isa_pkg::reg_idx_t rf_wr_addr;
    cpu_isa_pkg::data_t    rf_wd;

    fwd_if i_fwd ();

    register_file i_rf (
        .clk (clk), .rst_n (rst_n),
        .ra_addr (ra_addr), .rb_addr (rb_addr),
        .we (rf_we), .wr_addr (rf_wr_addr), .wd (rf_wd),
        .ra_val (ra_val), .rb_val (rb_val)
    );

    decode_stage i_decode (
        .clk (clk), .rst_n (rst_n),
        .instr_valid (instr_valid), .instr (instr), .in_port (in_port),
        .ra_val (ra_val), .rb_val (rb_val),
        .ra_addr (ra_addr), .rb_addr (rb_addr),
        .ex_ctrl (ex_ctrl), .ex_ra (ex_ra), .ex_rb (ex_rb),
        .ex_ra_val (ex_ra_val), .ex_rb_val (ex_rb_val), .ex_in_val (ex_in_val)
    );

    execute_stage i_execute (
        .clk (clk), .rst_n (rst_n),
        .ctrl (ex_ctrl), .ra (ex_ra), .rb (ex_rb),
        .ra_val (ex_ra_val), .rb_val (ex_rb_val), .in_val (ex_in_val),
        .fwd (i_fwd.sink), .fwd_out (i_fwd.src),       // same bus both ways
        .mem_ctrl (mem_ctrl), .mem_rd (mem_rd), .mem_result (mem_result)
    );

    writeback_stage i_writeback (
        .clk (clk), .rst_n (rst_n),
        .ctrl (mem_ctrl), .rd (mem_rd), .result (mem_result),
        .fwd (i_fwd.src),
        .rf_we (rf_we), .rf_wr_addr (rf_wr_addr), .rf_wd (rf_wd),
        .out_valid (out_valid), .out_port (out_port)
    );

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   instr_valid,
    input  wire [7:0]             instr,
    input  cpu_isa_pkg::data_t    in_port,
    input  cpu_isa_pkg::data_t    ra_val,     // register file read data
    input  cpu_isa_pkg::data_t    rb_val,
    output cpu_isa_pkg::reg_idx_t ra_addr,    // register file read addresses
    output cpu_isa_pkg::reg_idx_t rb_addr,
    output cpu_pipe_pkg::ctrl_t   ex_ctrl,    // ID/EX register outputs
    output cpu_isa_pkg::reg_idx_t ex_ra,
    output cpu_isa_pkg::reg_idx_t ex_rb,
    output cpu_isa_pkg::data_t    ex_ra_val,
    output cpu_isa_pkg::data_t    ex_rb_val,
    output cpu_isa_pkg::data_t    ex_in_val
);

    logic [7:0]           if_instr;    // IF/ID, zero means nop
    cpu_isa_pkg::data_t   if_in_val;   // port sampled with the instruction
    cpu_isa_pkg::opcode_e opcode;
    cpu_pipe_pkg::ctrl_t  dec_ctrl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr <= '0;
        end else begin
            if_instr <= instr_valid ? instr : 8'h00;  // idle slot becomes nop
        end
    end

    always_ff @(posedge clk) begin
        if_in_val <= in_port;
    end

    assign opcode  = cpu_isa_pkg::opcode_e'(if_instr[7:4]);
    assign ra_addr = if_instr[3:2];
    // out routes ra through the b operand
    assign rb_addr = (opcode == cpu_isa_pkg::op_out) ? if_instr[3:2] : if_instr[1:0];

    always_comb begin
        dec_ctrl.alu_op    = cpu_pipe_pkg::alu_pass_b;
        dec_ctrl.reg_write = 1'b1;  // most opcodes write ra
        dec_ctrl.io_write  = 1'b0;
        case (opcode)
            cpu_isa_pkg::op_mov: dec_ctrl.alu_op = cpu_pipe_pkg::alu_pass_b;
            cpu_isa_pkg::op_add: dec_ctrl.alu_op = cpu_pipe_pkg::alu_add;
            cpu_isa_pkg::op_sub: dec_ctrl.alu_op = cpu_pipe_pkg::alu_sub;
            cpu_isa_pkg::op_and: dec_ctrl.alu_op = cpu_pipe_pkg::alu_and;
            cpu_isa_pkg::op_or:  dec_ctrl.alu_op = cpu_pipe_pkg::alu_or;
            cpu_isa_pkg::op_not: dec_ctrl.alu_op = cpu_pipe_pkg::alu_not_a;
            cpu_isa_pkg::op_inc: dec_ctrl.alu_op = cpu_pipe_pkg::alu_inc_a;
            cpu_isa_pkg::op_dec: dec_ctrl.alu_op = cpu_pipe_pkg::alu_dec_a;
            cpu_isa_pkg::op_in:  dec_ctrl.alu_op = cpu_pipe_pkg::alu_pass_in;
            cpu_isa_pkg::op_out: begin
                dec_ctrl.reg_write = 1'b0;
                dec_ctrl.io_write  = 1'b1;  // b already holds ra
            end
            default: dec_ctrl.reg_write = 1'b0;  // nop and spare codes
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctrl <= cpu_pipe_pkg::ctrl_nop;
        end else begin
            ex_ctrl <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_ra     <= ra_addr;  // also the destination
        ex_rb     <= rb_addr;
        ex_ra_val <= ra_val;   // includes write-through
        ex_rb_val <= rb_val;
        ex_in_val <= if_in_val;
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  cpu_pipe_pkg::ctrl_t   ctrl,        // ID/EX
    input  cpu_isa_pkg::reg_idx_t ra,
    input  cpu_isa_pkg::reg_idx_t rb,
    input  cpu_isa_pkg::data_t    ra_val,
    input  cpu_isa_pkg::data_t    rb_val,
    input  cpu_isa_pkg::data_t    in_val,
    fwd_if.sink                   fwd,         // both later stages
    fwd_if.src                    fwd_out,     // drives the mem side
    output cpu_pipe_pkg::ctrl_t   mem_ctrl,    // EX/MEM
    output cpu_isa_pkg::reg_idx_t mem_rd,
    output cpu_isa_pkg::data_t    mem_result
);

    cpu_pipe_pkg::fwd_sel_e sel_a;
    cpu_pipe_pkg::fwd_sel_e sel_b;
    cpu_isa_pkg::data_t     op_a;
    cpu_isa_pkg::data_t     op_b;
    cpu_isa_pkg::data_t     alu_out;

    // nearest producer wins
    function automatic cpu_pipe_pkg::fwd_sel_e pick_src(cpu_isa_pkg::reg_idx_t idx);
        if (fwd.mem_we && (fwd.mem_rd == idx)) begin
            return cpu_pipe_pkg::fwd_mem;
        end
        if (fwd.wb_we && (fwd.wb_rd == idx)) begin
            return cpu_pipe_pkg::fwd_wb;
        end
        return cpu_pipe_pkg::fwd_none;
    endfunction

    function automatic cpu_isa_pkg::data_t operand(cpu_pipe_pkg::fwd_sel_e sel,
                                                   cpu_isa_pkg::data_t own);
        case (sel)
            cpu_pipe_pkg::fwd_mem: return fwd.mem_val;
            cpu_pipe_pkg::fwd_wb:  return fwd.wb_val;
            default:               return own;
        endcase
    endfunction

    always_comb begin
        sel_a = pick_src(ra);
        sel_b = pick_src(rb);
        op_a  = operand(sel_a, ra_val);
        op_b  = operand(sel_b, rb_val);
    end

    always_comb begin
        case (ctrl.alu_op)
            cpu_pipe_pkg::alu_pass_b:  alu_out = op_b;
            cpu_pipe_pkg::alu_add:     alu_out = op_a + op_b;  // wraps mod 256
            cpu_pipe_pkg::alu_sub:     alu_out = op_a - op_b;
            cpu_pipe_pkg::alu_and:     alu_out = op_a & op_b;
            cpu_pipe_pkg::alu_or:      alu_out = op_a | op_b;
            cpu_pipe_pkg::alu_not_a:   alu_out = ~op_a;
            cpu_pipe_pkg::alu_inc_a:   alu_out = op_a + cpu_isa_pkg::data_t'(1);
            cpu_pipe_pkg::alu_dec_a:   alu_out = op_a - cpu_isa_pkg::data_t'(1);
            cpu_pipe_pkg::alu_pass_in: alu_out = in_val;
            default:                   alu_out = op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctrl <= cpu_pipe_pkg::ctrl_nop;
        end else begin
            mem_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd     <= ra;  // destination is always ra
        mem_result <= alu_out;
    end

    assign fwd_out.mem_we  = mem_ctrl.reg_write;
    assign fwd_out.mem_rd  = mem_rd;
    assign fwd_out.mem_val = mem_result;

    // a value taken from the mem leg must be a real result
    a_mem_fwd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sel_a == cpu_pipe_pkg::fwd_mem || sel_b == cpu_pipe_pkg::fwd_mem)
            |-> !$isunknown(fwd.mem_val)
    );

endmodule

`default_nettype wire

// File: verilog/fwd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fwd_if;

    logic                  mem_we;   // EX/MEM entry writes a register
    cpu_isa_pkg::reg_idx_t mem_rd;   // its destination
    cpu_isa_pkg::data_t    mem_val;  // its result
    logic                  wb_we;    // MEM/WB entry writes a register
    cpu_isa_pkg::reg_idx_t wb_rd;
    cpu_isa_pkg::data_t    wb_val;

    // execute drives mem_*, writeback drives wb_*
    modport src (output mem_we, mem_rd, mem_val, wb_we, wb_rd, wb_val);

    modport sink (input mem_we, mem_rd, mem_val, wb_we, wb_rd, wb_val);

endinterface

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  cpu_isa_pkg::reg_idx_t ra_addr,   // from IF/ID
    input  cpu_isa_pkg::reg_idx_t rb_addr,
    input  wire                   we,        // from MEM/WB
    input  cpu_isa_pkg::reg_idx_t wr_addr,
    input  cpu_isa_pkg::data_t    wd,
    output cpu_isa_pkg::data_t    ra_val,
    output cpu_isa_pkg::data_t    rb_val
);

    cpu_isa_pkg::data_t regs [cpu_isa_pkg::reg_count];

    // write-through so a reader three behind sees the value being written
    function automatic cpu_isa_pkg::data_t read_port(cpu_isa_pkg::reg_idx_t addr);
        if (we && (wr_addr == addr)) begin
            return wd;  // bypass the array
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;  // all registers start at 0
            end
        end else if (we) begin
            regs[wr_addr] <= wd;
        end
    end

    always_comb begin
        ra_val = read_port(ra_addr);
        rb_val = read_port(rb_addr);
    end

    // writeback must never present a floating address with a live strobe
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(wr_addr)
    );

endmodule

`default_nettype wire

// File: verilog/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  cpu_pipe_pkg::ctrl_t   ctrl,        // EX/MEM
    input  cpu_isa_pkg::reg_idx_t rd,
    input  cpu_isa_pkg::data_t    result,
    fwd_if.src                    fwd,         // wb side only
    output logic                  rf_we,
    output cpu_isa_pkg::reg_idx_t rf_wr_addr,
    output cpu_isa_pkg::data_t    rf_wd,
    output logic                  out_valid,
    output cpu_isa_pkg::data_t    out_port
);

    cpu_pipe_pkg::ctrl_t   wb_ctrl;    // MEM/WB
    cpu_isa_pkg::reg_idx_t wb_rd;
    cpu_isa_pkg::data_t    wb_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ctrl <= cpu_pipe_pkg::ctrl_nop;
        end else begin
            wb_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd     <= rd;
        wb_result <= result;
    end

    assign rf_we      = wb_ctrl.reg_write;  // lands on the next edge
    assign rf_wr_addr = wb_rd;
    assign rf_wd      = wb_result;

    assign fwd.wb_we  = wb_ctrl.reg_write;
    assign fwd.wb_rd  = wb_rd;
    assign fwd.wb_val = wb_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_port  <= '0;
        end else begin
            out_valid <= wb_ctrl.io_write;  // one-cycle strobe
            if (wb_ctrl.io_write) begin
                out_port <= wb_result;      // held until the next out
            end
        end
    end

    // decode never issues an entry that is both a register write and an out
    a_one_sink: assert property (
        @(posedge clk) disable iff (!rst_n) !(wb_ctrl.reg_write && wb_ctrl.io_write)
    );

endmodule

`default_nettype wire
